/* src/slope_pkg.sv */
`default_nettype none

package slope_pkg;

    // Screen coordinates are unsigned 12-bit values
    // The same width holds an absolute delta and a step count
    localparam int unsigned coord_width = 12;

    // The slope fraction is unsigned Q1.16
    localparam int unsigned frac_bits = 16;

    // One extra quotient bit so that a slope of exactly 1.0 fits
    localparam int unsigned quo_width = frac_bits + 1;

    // The dividend is the minor delta moved up by the fraction bits
    localparam int unsigned num_width = coord_width + frac_bits;

    // Incoming line segment, start point first
    typedef struct packed {
        logic [coord_width-1:0] x0;
        logic [coord_width-1:0] y0;
        logic [coord_width-1:0] x1;
        logic [coord_width-1:0] y1;
    } edge_t;

    // Geometry that waits beside the divider
    typedef struct packed {
        logic                   major_is_x;
        logic                   x_neg;
        logic                   y_neg;
        logic [coord_width-1:0] steps;
    } prep_t;

    // Finished slope record, geometry followed by the fraction
    typedef struct packed {
        logic                   major_is_x;
        logic                   x_neg;
        logic                   y_neg;
        logic [coord_width-1:0] steps;
        logic [quo_width-1:0]   frac;
    } slope_t;

    // Divider sequencing
    typedef enum logic [0:0] {
        div_idle = 1'b0,
        div_run  = 1'b1
    } div_state_e;

endpackage

`default_nettype wire

/* src/int_div.sv */
`timescale 1ns/1ps
`default_nettype none

// Restoring unsigned divider that resolves one quotient bit per clock,
// most significant bit first
module int_div
    import slope_pkg::*;
#(
    parameter int unsigned num_width = slope_pkg::num_width,
    parameter int unsigned quo_width = slope_pkg::quo_width
) (
    input  wire logic                 clk_i,
    input  wire logic                 reset_ni,
    input  wire logic                 start_i,
    input  wire logic [num_width-1:0] dividend_i,
    input  wire logic [num_width-1:0] divisor_i,
    output logic      [quo_width-1:0] quotient_o,
    output logic                      valid_o
);

    // The working registers are wide enough for the divisor shifted by
    // the full quotient width without losing any bit
    typedef logic [num_width+quo_width-1:0] wide_t;

    // Index of the quotient bit under test
    typedef logic [$clog2(quo_width)-1:0] pos_t;

    div_state_e state_q;
    wide_t      remainder_q;
    wide_t      divisor_q;
    pos_t       bit_pos_q;

    wide_t      shifted_div;
    logic       fits;
    logic       zero_operand;

    // Trial subtrahend for the current bit
    always_comb begin
        shifted_div = divisor_q << bit_pos_q;
        fits        = (remainder_q >= shifted_div);
    end

    // Either operand at zero needs no iteration and answers zero at once
    assign zero_operand = (dividend_i == '0) || (divisor_i == '0);

    // Control state
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q   <= div_idle;
            bit_pos_q <= '0;
            valid_o   <= 1'b0;
        end else begin
            case (state_q)
                div_idle: begin
                    // A zero operand finishes in the cycle after start
                    valid_o <= start_i && zero_operand;
                    if (start_i && !zero_operand) begin
                        state_q   <= div_run;
                        bit_pos_q <= pos_t'(quo_width - 1);
                    end
                end
                div_run: begin
                    bit_pos_q <= bit_pos_q - 1'b1;
                    // Last bit resolved, so the quotient is complete
                    if (bit_pos_q == '0) begin
                        state_q <= div_idle;
                        valid_o <= 1'b1;
                    end
                end
                default: begin
                    state_q <= div_idle;
                    valid_o <= 1'b0;
                end
            endcase
        end
    end

    // Datapath with no reset, loaded on start
    always_ff @(posedge clk_i) begin
        case (state_q)
            div_idle: begin
                if (start_i) begin
                    quotient_o  <= '0;
                    remainder_q <= wide_t'(dividend_i);
                    divisor_q   <= wide_t'(divisor_i);
                end
            end
            div_run: begin
                // Restore by simply not subtracting when the trial fails
                if (fits) begin
                    remainder_q           <= remainder_q - shifted_div;
                    quotient_o[bit_pos_q] <= 1'b1;
                end
            end
            default: begin
                quotient_o <= '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/edge_prep.sv */
`timescale 1ns/1ps
`default_nettype none

// Front end of the slope unit
// Takes one edge at a time and turns it into a divide job plus geometry
module edge_prep
    import slope_pkg::*;
(
    input  wire logic                 clk_i,
    input  wire logic                 reset_ni,
    input  wire edge_t                edge_i,
    input  wire logic                 edge_valid_i,
    input  wire logic                 done_i,
    output logic                      busy_o,
    output logic                      div_start_o,
    output logic      [num_width-1:0] dividend_o,
    output logic      [num_width-1:0] divisor_o,
    output prep_t                     prep_o,
    output logic                      prep_valid_o
);

    edge_t edge_q;
    logic  pend_q;
    logic  launch_q;
    logic  accept;

    // One bit wider than a coordinate to carry the sign of the difference
    logic signed [coord_width:0] dx;
    logic signed [coord_width:0] dy;
    logic [coord_width-1:0]      abs_dx;
    logic [coord_width-1:0]      abs_dy;
    logic [coord_width-1:0]      major;
    logic [coord_width-1:0]      minor;
    logic                        x_neg;
    logic                        y_neg;
    logic                        major_is_x;

    // Strobes that arrive while an edge is in work are ignored
    assign accept = edge_valid_i && !busy_o;

    always_comb begin
        dx     = $signed({1'b0, edge_q.x1}) - $signed({1'b0, edge_q.x0});
        dy     = $signed({1'b0, edge_q.y1}) - $signed({1'b0, edge_q.y0});
        x_neg  = (edge_q.x1 < edge_q.x0);
        y_neg  = (edge_q.y1 < edge_q.y0);
        // The magnitude always fits back into a coordinate
        abs_dx = x_neg ? coord_width'(-dx) : coord_width'(dx);
        abs_dy = y_neg ? coord_width'(-dy) : coord_width'(dy);
        // A diagonal counts as x-major
        major_is_x = (abs_dx >= abs_dy);
        major      = major_is_x ? abs_dx : abs_dy;
        minor      = major_is_x ? abs_dy : abs_dx;
    end

    // An edge is accepted, launched one cycle later and then held until done
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            busy_o   <= 1'b0;
            pend_q   <= 1'b0;
            launch_q <= 1'b0;
        end else begin
            pend_q   <= accept;
            launch_q <= pend_q;
            if (accept) begin
                busy_o <= 1'b1;
            end else if (done_i) begin
                busy_o <= 1'b0;
            end
        end
    end

    // Edge capture and job registers
    always_ff @(posedge clk_i) begin
        if (accept) begin
            edge_q <= edge_i;
        end
        if (pend_q) begin
            dividend_o        <= {minor, {frac_bits{1'b0}}};
            divisor_o         <= {{frac_bits{1'b0}}, major};
            prep_o.major_is_x <= major_is_x;
            prep_o.x_neg      <= x_neg;
            prep_o.y_neg      <= y_neg;
            prep_o.steps      <= major;
        end
    end

    // Divider start and geometry hand-off share the same pulse
    assign div_start_o  = launch_q;
    assign prep_valid_o = launch_q;

endmodule

`default_nettype wire

/* src/slope_finish.sv */
`timescale 1ns/1ps
`default_nettype none

// Back end of the slope unit
// Parks the geometry until the quotient arrives, then emits the record
module slope_finish
    import slope_pkg::*;
(
    input  wire logic                 clk_i,
    input  wire logic                 reset_ni,
    input  wire prep_t                prep_i,
    input  wire logic                 prep_valid_i,
    input  wire logic [quo_width-1:0] quotient_i,
    input  wire logic                 quo_valid_i,
    output slope_t                    slope_o,
    output logic                      slope_valid_o
);

    prep_t geom_q;

    // Geometry is taken one cycle before the earliest quotient
    always_ff @(posedge clk_i) begin
        if (prep_valid_i) begin
            geom_q <= prep_i;
        end
    end

    // The output record reads zero until the first result
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            slope_o <= '0;
        end else if (quo_valid_i) begin
            slope_o.major_is_x <= geom_q.major_is_x;
            slope_o.x_neg      <= geom_q.x_neg;
            slope_o.y_neg      <= geom_q.y_neg;
            slope_o.steps      <= geom_q.steps;
            slope_o.frac       <= quotient_i;
        end
    end

    // Single-cycle result strobe
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            slope_valid_o <= 1'b0;
        end else begin
            slope_valid_o <= quo_valid_i;
        end
    end

endmodule

`default_nettype wire

/* src/edge_slope_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// Edge slope setup for the scanline rasterizer
// Edge in, slope record out, one edge in flight at a time
module edge_slope_unit
    import slope_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   reset_ni,
    input  wire edge_t  edge_i,
    input  wire logic   edge_valid_i,
    output logic        busy_o,
    output slope_t      slope_o,
    output logic        slope_valid_o
);

    logic                 div_start;
    logic [num_width-1:0] dividend;
    logic [num_width-1:0] divisor;
    prep_t                prep;
    logic                 prep_valid;
    logic [quo_width-1:0] quotient;
    logic                 quo_valid;

    // The result strobe also tells the front end that the edge is done
    edge_prep i_edge_prep (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .edge_i       (edge_i),
        .edge_valid_i (edge_valid_i),
        .done_i       (slope_valid_o),
        .busy_o       (busy_o),
        .div_start_o  (div_start),
        .dividend_o   (dividend),
        .divisor_o    (divisor),
        .prep_o       (prep),
        .prep_valid_o (prep_valid)
    );

    int_div #(
        .num_width (num_width),
        .quo_width (quo_width)
    ) i_int_div (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .start_i    (div_start),
        .dividend_i (dividend),
        .divisor_i  (divisor),
        .quotient_o (quotient),
        .valid_o    (quo_valid)
    );

    slope_finish i_slope_finish (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .prep_i        (prep),
        .prep_valid_i  (prep_valid),
        .quotient_i    (quotient),
        .quo_valid_i   (quo_valid),
        .slope_o       (slope_o),
        .slope_valid_o (slope_valid_o)
    );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and a synchronous active-low reset for the testbench
module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 2
) (
    output logic clk_o,
    output logic reset_no
);

    // Half a period low, half a period high, starting low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(period_ns / 2) clk_o = ~clk_o;
        end
    end

    // Reset covers the first rising edges and lets go on a falling edge,
    // well away from the instants where the DUT samples it
    initial begin
        reset_no = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        @(negedge clk_o);
        reset_no = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_edge_slope.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_edge_slope
    import slope_pkg::*;
();

    localparam int period_ns      = 40;
    localparam int drive_delay_ns = 2;
    localparam int seed_init      = 51;
    localparam int timeout_cycles = 50;
    localparam int random_edges   = 40;
    localparam int quiet_cycles   = 25;

    // Each row of the directed table also holds the cycles from the
    // accepting clock edge to the result pulse
    typedef struct {
        edge_t  stim;
        slope_t exp_slope;
        int     latency;
    } vec_t;

    logic   clk_i;
    logic   reset_ni;
    edge_t  edge_i;
    logic   edge_valid_i;
    logic   busy_o;
    slope_t slope_o;
    logic   slope_valid_o;

    vec_t   table_q[$];
    integer seed;

    tb_clock_gen #(
        .period_ns    (period_ns),
        .reset_cycles (2)
    ) i_tb_clock_gen (
        .clk_o    (clk_i),
        .reset_no (reset_ni)
    );

    edge_slope_unit i_edge_slope_unit (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .edge_i        (edge_i),
        .edge_valid_i  (edge_valid_i),
        .busy_o        (busy_o),
        .slope_o       (slope_o),
        .slope_valid_o (slope_valid_o)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_bit(input string name, input logic expv, input logic actv);
        if (actv !== expv) begin
            fail_run($sformatf("Fail at %0t ns: %s expected %b got %b",
                               $time, name, expv, actv));
        end
    endtask

    task automatic check_slope(input string name, input slope_t expv, input slope_t actv);
        if (actv !== expv) begin
            fail_run($sformatf("Fail at %0t ns: %s expected %h (frac %0d) got %h (frac %0d)",
                               $time, name, expv, expv.frac, actv, actv.frac));
        end
    endtask

    // Every drive and every sample happens a little after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #(drive_delay_ns);
    endtask

    task automatic wait_for_reset();
        int n;
        n = 0;
        while (reset_ni !== 1'b1) begin
            if (n >= timeout_cycles) begin
                fail_run("Timeout: reset_ni was never released");
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    // Counts the cycles until the result pulse shows up
    task automatic wait_for_result(output int cycles);
        cycles = 0;
        while (slope_valid_o !== 1'b1) begin
            if (cycles >= timeout_cycles) begin
                fail_run("Timeout: slope_valid_o never pulsed for the edge in work");
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    task automatic wait_for_idle();
        int n;
        n = 0;
        while (busy_o !== 1'b0) begin
            if (n >= timeout_cycles) begin
                fail_run("Timeout: busy_o stayed high");
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    // Expected record from the deltas, the directions, the major axis and
    // the truncated fraction
    function automatic slope_t expected_slope(input edge_t e);
        slope_t s;
        int     adx;
        int     ady;
        int     big_d;
        int     small_d;
        longint q;
        adx = int'(e.x1) - int'(e.x0);
        ady = int'(e.y1) - int'(e.y0);
        adx = (adx < 0) ? -adx : adx;
        ady = (ady < 0) ? -ady : ady;
        s.major_is_x = (adx >= ady);
        s.x_neg      = (e.x1 < e.x0);
        s.y_neg      = (e.y1 < e.y0);
        big_d        = (adx >= ady) ? adx : ady;
        small_d      = (adx >= ady) ? ady : adx;
        s.steps      = coord_width'(big_d);
        if (big_d == 0 || small_d == 0) begin
            q = 0;
        end else begin
            q = (longint'(small_d) * 65536) / big_d;
        end
        s.frac = quo_width'(q);
        return s;
    endfunction

    // A zero delta skips the divide loop
    function automatic int expected_latency(input edge_t e);
        if (e.x1 == e.x0 || e.y1 == e.y0) begin
            return 3;
        end
        return 20;
    endfunction

    task automatic add_vec(input int x0, input int y0, input int x1, input int y1,
                           input int mx, input int xn, input int yn,
                           input int steps, input int frac, input int lat);
        vec_t v;
        v.stim.x0              = coord_width'(x0);
        v.stim.y0              = coord_width'(y0);
        v.stim.x1              = coord_width'(x1);
        v.stim.y1              = coord_width'(y1);
        v.exp_slope.major_is_x = mx[0];
        v.exp_slope.x_neg      = xn[0];
        v.exp_slope.y_neg      = yn[0];
        v.exp_slope.steps      = coord_width'(steps);
        v.exp_slope.frac       = quo_width'(frac);
        v.latency              = lat;
        table_q.push_back(v);
    endtask

    task automatic build_table();
        // Axis-aligned edges in all four directions
        add_vec(100, 200, 150, 200, 1, 0, 0, 50, 0, 3);
        add_vec(150, 200, 100, 200, 1, 1, 0, 50, 0, 3);
        add_vec(300, 10, 300, 90, 0, 0, 0, 80, 0, 3);
        add_vec(300, 90, 300, 10, 0, 0, 1, 80, 0, 3);
        // Diagonals report x as the major axis and a slope of 1.0
        add_vec(10, 10, 40, 40, 1, 0, 0, 30, 65536, 20);
        add_vec(40, 10, 10, 40, 1, 1, 0, 30, 65536, 20);
        add_vec(10, 40, 40, 10, 1, 0, 1, 30, 65536, 20);
        add_vec(40, 40, 10, 10, 1, 1, 1, 30, 65536, 20);
        // A single point
        add_vec(512, 512, 512, 512, 1, 0, 0, 0, 0, 3);
        // One general edge per octant
        add_vec(0, 0, 3, 1, 1, 0, 0, 3, 21845, 20);
        add_vec(0, 0, 1, 3, 0, 0, 0, 3, 21845, 20);
        add_vec(100, 50, 93, 52, 1, 1, 0, 7, 18724, 20);
        add_vec(100, 50, 98, 57, 0, 1, 0, 7, 18724, 20);
        add_vec(200, 200, 195, 197, 1, 1, 1, 5, 39321, 20);
        add_vec(200, 200, 197, 195, 0, 1, 1, 5, 39321, 20);
        add_vec(0, 4095, 4095, 4094, 1, 0, 1, 4095, 16, 20);
        add_vec(0, 4095, 1, 0, 0, 0, 1, 4095, 16, 20);
        add_vec(20, 30, 27, 20, 0, 0, 1, 10, 45875, 20);
        // Full-range edge just below 1.0
        add_vec(0, 0, 4095, 4094, 1, 0, 0, 4095, 65519, 20);
    endtask

    task automatic draw_edge(output edge_t e);
        e.x0 = coord_width'($random(seed));
        e.y0 = coord_width'($random(seed));
        e.x1 = coord_width'($random(seed));
        e.y1 = coord_width'($random(seed));
    endtask

    // Strobes one edge, then checks busy, the latency, the record and the
    // fall of busy on the clock after the pulse
    task automatic run_edge(input edge_t e, input slope_t exp_s, input int exp_lat);
        int lat;
        edge_i       = e;
        edge_valid_i = 1'b1;
        next_cycle();
        edge_valid_i = 1'b0;
        // Scramble the input so that only the captured copy can be right
        edge_i = ~e;
        check_bit("busy_o", 1'b1, busy_o);
        wait_for_result(lat);
        if (lat != exp_lat) begin
            fail_run($sformatf("Fail at %0t ns: slope_valid_o latency expected %0d got %0d",
                               $time, exp_lat, lat));
        end
        check_slope("slope_o", exp_s, slope_o);
        check_bit("busy_o", 1'b1, busy_o);
        next_cycle();
        check_bit("slope_valid_o", 1'b0, slope_valid_o);
        check_bit("busy_o", 1'b0, busy_o);
    endtask

    // A strobe in the middle of a divide must vanish without a trace
    task automatic drop_while_busy();
        edge_t a;
        edge_t b;
        int    cycles;
        int    n;
        a = {12'd0, 12'd0, 12'd9, 12'd4};
        b = {12'd50, 12'd50, 12'd10, 12'd60};
        wait_for_idle();
        edge_i       = a;
        edge_valid_i = 1'b1;
        next_cycle();
        edge_valid_i = 1'b0;
        edge_i       = b;
        cycles       = 0;
        repeat (3) begin
            next_cycle();
            cycles++;
        end
        check_bit("busy_o", 1'b1, busy_o);
        edge_valid_i = 1'b1;
        next_cycle();
        cycles++;
        edge_valid_i = 1'b0;
        wait_for_result(n);
        cycles += n;
        if (cycles != 20) begin
            fail_run($sformatf("Fail at %0t ns: slope_valid_o latency expected 20 got %0d",
                               $time, cycles));
        end
        check_slope("slope_o", expected_slope(a), slope_o);
        next_cycle();
        check_bit("busy_o", 1'b0, busy_o);
        repeat (quiet_cycles) begin
            check_bit("slope_valid_o", 1'b0, slope_valid_o);
            next_cycle();
        end
    endtask

    initial begin
        edge_t e;
        edge_i       = '0;
        edge_valid_i = 1'b0;
        seed         = seed_init;
        build_table();
        wait_for_reset();
        // Outputs after reset
        check_bit("busy_o", 1'b0, busy_o);
        check_bit("slope_valid_o", 1'b0, slope_valid_o);
        check_slope("slope_o", '0, slope_o);
        foreach (table_q[i]) begin
            run_edge(table_q[i].stim, table_q[i].exp_slope, table_q[i].latency);
        end
        drop_while_busy();
        repeat (random_edges) begin
            draw_edge(e);
            run_edge(e, expected_slope(e), expected_latency(e));
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/slope_pkg.sv
src/int_div.sv
src/edge_prep.sv
src/slope_finish.sv
src/edge_slope_unit.sv
sim/tb_clock_gen.sv
sim/tb_edge_slope.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0 -Wno-fatal
LINTFLAGS := --lint-only -Wall
TOP       := tb_edge_slope
RTL_TOP   := edge_slope_unit
FILELIST  := compile.f
RTL_SRCS  := src/slope_pkg.sv src/int_div.sv src/edge_prep.sv \
             src/slope_finish.sv src/edge_slope_unit.sv
OBJ_DIR   := obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass message appears as a line of its own
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
